// ==== tb.f ====
logic/panel_pkg.sv
logic/button_conditioner.sv
logic/step_timer.sv
logic/run_control.sv
logic/front_panel.sv
testbench/run_control_checker.sv
testbench/tb_front_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the front panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_front_panel \
    -Mdir obj_dir -o sim_front_panel
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_front_panel
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

// ==== testbench/tb_front_panel.sv ====
module tb_front_panel;

    timeunit 1ns;
    timeprecision 100ps;

    import panel_pkg::*;

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int RUN_PERIOD      = 24;

    // step_ready driver modes
    localparam int READY_RANDOM = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_HIGH   = 2;

    // conditions for wait_until
    localparam int WAIT_IDLE  = 0;
    localparam int WAIT_VALID = 1;

    logic                 clk;
    logic                 db_resetn;
    logic [N_BUTTONS-1:0] button;
    logic                 step_ready;
    logic                 step_valid;
    logic                 led_run_status;
    logic                 led_idle;
    logic [STEP_W-1:0]    led_run_step;

    int                   seed;
    int                   ready_seed;
    int                   ready_word;
    int                   ready_mode;
    run_state_t           exp_state;
    logic [STEP_W-1:0]    model_cnt;
    int                   total_transfers;

    front_panel #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .RUN_PERIOD     (RUN_PERIOD)
    ) dut (
        .clk            (clk),
        .db_resetn      (db_resetn),
        .button         (button),
        .step_ready     (step_ready),
        .step_valid     (step_valid),
        .led_run_status (led_run_status),
        .led_idle       (led_idle),
        .led_run_step   (led_run_step)
    );

    bind run_control run_control_checker u_checker (
        .clk            (clk),
        .db_resetn      (db_resetn),
        .step_valid     (step_valid),
        .step_ready     (step_ready),
        .led_idle       (led_idle),
        .led_run_status (led_run_status)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else begin
            fail_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
        end
    endtask

    function automatic logic rand_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + (int'(r[15:0]) % (hi - lo + 1));
    endfunction

    function automatic logic condition_met(input int sel);
        logic met;
        met = 1'b0;
        if (sel == WAIT_IDLE) begin
            met = led_idle && !step_valid;
        end else if (sel == WAIT_VALID) begin
            met = step_valid;
        end
        return met;
    endfunction

    task automatic wait_until(input int sel, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!condition_met(sel) && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (condition_met(sel)) else begin
            fail_run($sformatf("timed out waiting for %s", what));
        end
    endtask

    // applied from the falling edge so the driver sees it at the next rising edge
    task automatic set_ready(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    task automatic drive_bit(input int idx, input logic val);
        logic [N_BUTTONS-1:0] mask;
        mask = N_BUTTONS'(1) << idx;
        @(posedge clk);
        if (val) begin
            button <= button | mask;
        end else begin
            button <= button & ~mask;
        end
    endtask

    task automatic press_button(input int idx);
        int bounce;
        int hold;
        int k;
        bounce = rand_range(1, 5);
        hold   = rand_range(20, 60);
        // contact bounce, steady hold, bounce again on release
        for (k = 0; k < bounce; k++) begin
            drive_bit(idx, rand_bit());
        end
        for (k = 0; k < hold; k++) begin
            drive_bit(idx, 1'b1);
        end
        bounce = rand_range(1, 5);
        for (k = 0; k < bounce; k++) begin
            drive_bit(idx, rand_bit());
        end
        drive_bit(idx, 1'b0);
        repeat (DEBOUNCE_CYCLES + 8) @(posedge clk);
        @(negedge clk);
    endtask

    // reference state table applied once the press has settled
    task automatic press_and_track(input int idx);
        press_button(idx);
        if (exp_state == IDLE && idx == BTN_STEP) begin
            wait_until(WAIT_IDLE, 200, "the single step to complete");
        end
        if (exp_state == IDLE && idx == BTN_RUN) begin
            exp_state = RUN;
        end else if (exp_state == RUN && idx == BTN_STOP) begin
            exp_state = IDLE;
        end
        check_hex("led_idle", 32'(led_idle), 32'(exp_state == IDLE));
        check_hex("led_run_status", 32'(led_run_status), 32'(exp_state == RUN));
    endtask

    // core side back-pressure on its own random stream
    always @(posedge clk) begin
        if (ready_mode == READY_RANDOM) begin
            ready_word = $random(ready_seed);
            step_ready <= ready_word[0];
        end else if (ready_mode == READY_HIGH) begin
            step_ready <= 1'b1;
        end else begin
            step_ready <= 1'b0;
        end
    end

    // valid and ready together complete a transfer at the next edge
    always @(negedge clk) begin
        if (db_resetn) begin
            model_cnt       <= '0;
            total_transfers <= 0;
        end else begin
            assert (led_run_step == model_cnt) else begin
                fail_run($sformatf("[FAIL] led_run_step expected 0x%h got 0x%h",
                                   model_cnt, led_run_step));
            end
            if (step_valid && step_ready) begin
                model_cnt       <= model_cnt + 1'b1;
                total_transfers <= total_transfers + 1;
            end
        end
    end

    initial begin
        logic [STEP_W-1:0] c0;
        logic [STEP_W-1:0] exp_cnt;
        int                t0;
        int                n;
        int                idx;
        int                len;
        int                k;
        clk        = 1'b0;
        db_resetn  = 1'b1;
        button     = '0;
        step_ready = 1'b0;
        ready_mode = READY_RANDOM;
        seed       = 32'h8cd2035a;
        ready_seed = $random(seed);
        exp_state  = IDLE;

        repeat (2) @(posedge clk);
        db_resetn <= 1'b0;
        @(negedge clk);
        check_hex("led_idle", 32'(led_idle), 32'd1);
        check_hex("led_run_status", 32'(led_run_status), 32'd0);
        check_hex("led_run_step", 32'(led_run_step), 32'd0);
        check_hex("step_valid", 32'(step_valid), 32'd0);

        // single steps from idle
        repeat (3) begin
            c0      = model_cnt;
            exp_cnt = c0 + 1'b1;
            press_and_track(BTN_STEP);
            check_hex("led_run_step", 32'(led_run_step), 32'(exp_cnt));
        end

        // glitches shorter than the debounce window
        repeat (8) begin
            idx = rand_range(0, N_BUTTONS - 1);
            len = rand_range(1, DEBOUNCE_CYCLES - 1);
            c0  = model_cnt;
            for (k = 0; k < len; k++) begin
                drive_bit(idx, 1'b1);
            end
            drive_bit(idx, 1'b0);
            repeat (40) begin
                @(negedge clk);
                check_hex("step_valid", 32'(step_valid), 32'd0);
                check_hex("led_idle", 32'(led_idle), 32'd1);
                check_hex("led_run_step", 32'(led_run_step), 32'(c0));
            end
        end

        // continuous run long enough to wrap the count
        t0 = total_transfers;
        press_and_track(BTN_RUN);
        n = 0;
        while (total_transfers - t0 < 20 && n < 3000) begin
            @(negedge clk);
            n++;
        end
        assert (total_transfers - t0 >= 20) else begin
            fail_run("run mode did not issue twenty steps in time");
        end
        press_and_track(BTN_STOP);
        wait_until(WAIT_IDLE, 200, "the last run step to complete");

        // held request in step mode
        set_ready(READY_LOW);
        c0      = model_cnt;
        exp_cnt = c0 + 1'b1;
        press_button(BTN_STEP);
        wait_until(WAIT_VALID, 100, "a step request");
        repeat (30) begin
            @(negedge clk);
            check_hex("step_valid", 32'(step_valid), 32'd1);
            check_hex("led_run_step", 32'(led_run_step), 32'(c0));
        end
        set_ready(READY_HIGH);
        wait_until(WAIT_IDLE, 20, "the held step to be accepted");
        check_hex("led_run_step", 32'(led_run_step), 32'(exp_cnt));

        // held request in run mode
        set_ready(READY_LOW);
        press_and_track(BTN_RUN);
        wait_until(WAIT_VALID, 4 * RUN_PERIOD, "a paced request");
        c0      = model_cnt;
        exp_cnt = c0 + 1'b1;
        repeat (3 * RUN_PERIOD) begin
            @(negedge clk);
            check_hex("step_valid", 32'(step_valid), 32'd1);
            check_hex("led_run_step", 32'(led_run_step), 32'(c0));
        end
        set_ready(READY_HIGH);
        set_ready(READY_LOW);
        repeat (2 * RUN_PERIOD) @(negedge clk);
        check_hex("led_run_step", 32'(led_run_step), 32'(exp_cnt));

        // presses that do not apply in the current state
        set_ready(READY_RANDOM);
        press_and_track(BTN_RUN);
        press_and_track(BTN_STEP);
        press_and_track(BTN_STOP);
        wait_until(WAIT_IDLE, 200, "the run step after stop");
        c0 = model_cnt;
        press_and_track(BTN_STOP);
        check_hex("led_run_step", 32'(led_run_step), 32'(c0));
        check_hex("step_valid", 32'(step_valid), 32'd0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== testbench/run_control_checker.sv ====
module run_control_checker (
    input logic clk,
    input logic db_resetn,
    input logic step_valid,
    input logic step_ready,
    input logic led_idle,
    input logic led_run_status
);

    timeunit 1ns;
    timeprecision 100ps;

    // a pending request is held until the core takes it
    a_valid_held: assert property (@(posedge clk) disable iff (db_resetn)
        (step_valid && !step_ready) |=> step_valid)
        else $error("step_valid dropped without a step_ready handshake");

    a_led_exclusive: assert property (@(posedge clk) disable iff (db_resetn)
        !(led_idle && led_run_status))
        else $error("led_idle and led_run_status are both lit");

    a_valid_after_reset: assert property (@(posedge clk)
        $fell(db_resetn) |-> !step_valid)
        else $error("step_valid is set in the first cycle after reset");

endmodule

// ==== logic/front_panel.sv ====
module front_panel #(
    parameter int DEBOUNCE_CYCLES = 1000,
    parameter int RUN_PERIOD      = 1000000
) (
    input  logic                            clk,
    input  logic                            db_resetn,
    input  logic [panel_pkg::N_BUTTONS-1:0] button,
    input  logic                            step_ready,
    output logic                            step_valid,
    output logic                            led_run_status,
    output logic                            led_idle,
    output logic [panel_pkg::STEP_W-1:0]    led_run_step
);

    import panel_pkg::*;

    logic [N_BUTTONS-1:0] press;
    logic                 tick;

    // raw pins to one cycle press events
    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_button_conditioner (
        .clk       (clk),
        .db_resetn (db_resetn),
        .button    (button),
        .press     (press)
    );

    // pacing for continuous run
    step_timer #(
        .RUN_PERIOD(RUN_PERIOD)
    ) u_step_timer (
        .clk       (clk),
        .db_resetn (db_resetn),
        .tick      (tick)
    );

    run_control u_run_control (
        .clk            (clk),
        .db_resetn      (db_resetn),
        .press          (press),
        .tick           (tick),
        .step_ready     (step_ready),
        .step_valid     (step_valid),
        .led_run_status (led_run_status),
        .led_idle       (led_idle),
        .led_run_step   (led_run_step)
    );

endmodule

// ==== logic/run_control.sv ====
module run_control (
    input  logic                            clk,
    input  logic                            db_resetn,
    input  logic [panel_pkg::N_BUTTONS-1:0] press,
    input  logic                            tick,
    input  logic                            step_ready,
    output logic                            step_valid,
    output logic                            led_run_status,
    output logic                            led_idle,
    output logic [panel_pkg::STEP_W-1:0]    led_run_step
);

    import panel_pkg::*;

    run_state_t        state;
    run_state_t        state_next;
    logic              valid_q;
    logic              valid_next;
    logic              transfer;
    logic [STEP_W-1:0] step_cnt;

    // one microstep handed to the core
    assign transfer = valid_q & step_ready;

    always_comb begin
        state_next = state;
        // an accepted request drops, otherwise it stays pending
        valid_next = valid_q & ~transfer;

        case (state)
            IDLE: begin
                // run has priority over step
                if (press[BTN_RUN]) begin
                    state_next = RUN;
                end else if (press[BTN_STEP]) begin
                    state_next = STEP;
                    valid_next = 1'b1;
                end
            end

            RUN: begin
                // ticks during a pending request are dropped
                if (tick && !valid_q) begin
                    valid_next = 1'b1;
                end
                if (press[BTN_STOP]) begin
                    state_next = IDLE;
                end
            end

            STEP: begin
                if (transfer) begin
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (db_resetn) begin
            state   <= IDLE;
            valid_q <= 1'b0;
        end else begin
            state   <= state_next;
            valid_q <= valid_next;
        end
    end

    // accepted steps, wraps mod 16
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            step_cnt <= '0;
        end else if (transfer) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step_valid     = valid_q;
    assign led_run_status = (state == RUN);
    assign led_idle       = (state == IDLE);
    assign led_run_step   = step_cnt;

endmodule

// ==== logic/step_timer.sv ====
module step_timer #(
    parameter int RUN_PERIOD = 1000000
) (
    input  logic clk,
    input  logic db_resetn,
    output logic tick
);

    localparam int CNT_W = $clog2(RUN_PERIOD + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RUN_PERIOD - 1);

    logic [CNT_W-1:0] period_cnt;
    logic             tick_q;

    // free running, not gated by the controller state
    always_ff @(posedge clk) begin
        if (db_resetn) begin
            period_cnt <= '0;
            tick_q     <= 1'b0;
        end else begin
            if (period_cnt == CNT_LAST) begin
                period_cnt <= '0;
                tick_q     <= 1'b1;
            end else begin
                period_cnt <= period_cnt + 1'b1;
                tick_q     <= 1'b0;
            end
        end
    end

    assign tick = tick_q;

endmodule

// ==== logic/button_conditioner.sv ====
module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1000
) (
    input  logic                            clk,
    input  logic                            db_resetn,
    input  logic [panel_pkg::N_BUTTONS-1:0] button,
    output logic [panel_pkg::N_BUTTONS-1:0] press
);

    import panel_pkg::*;

    // wide enough to hold DEBOUNCE_CYCLES - 1
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    genvar i;

    generate
        for (i = 0; i < N_BUTTONS; i++) begin : g_btn
            logic             sync_0;
            logic             sync_1;
            logic [CNT_W-1:0] stable_cnt;
            logic             level;
            logic             press_q;

            // two flop synchronizer for the asynchronous pin
            always_ff @(posedge clk) begin
                if (db_resetn) begin
                    sync_0 <= 1'b0;
                    sync_1 <= 1'b0;
                end else begin
                    sync_0 <= button[i];
                    sync_1 <= sync_0;
                end
            end

            // level follows the input only after it has held
            // a new value for DEBOUNCE_CYCLES cycles in a row
            always_ff @(posedge clk) begin
                if (db_resetn) begin
                    stable_cnt <= '0;
                    level      <= 1'b0;
                    press_q    <= 1'b0;
                end else begin
                    press_q <= 1'b0;
                    if (sync_1 != level) begin
                        if (stable_cnt == CNT_LAST) begin
                            stable_cnt <= '0;
                            level      <= sync_1;
                            // only the rising edge makes a press
                            press_q    <= sync_1;
                        end else begin
                            stable_cnt <= stable_cnt + 1'b1;
                        end
                    end else begin
                        // bounce back to old level, start over
                        stable_cnt <= '0;
                    end
                end
            end

            assign press[i] = press_q;
        end
    endgenerate

endmodule

// ==== logic/panel_pkg.sv ====
package panel_pkg;

    // run controller state
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        STEP = 2'd2
    } run_state_t;

    // conditioned buttons on the panel
    localparam int N_BUTTONS = 4;

    // bit positions in the button word
    // bit 1 is the spare
    localparam int BTN_RUN  = 0;
    localparam int BTN_STEP = 2;
    localparam int BTN_STOP = 3;

    // step counter width, count wraps after 16
    localparam int STEP_W = 4;

endpackage
